// File: common/heapConfigPkg.sv
/*
  Heap geometry: array count, array length and element width,
  plus the index, size, tally and element types built from them
*/
package heapConfigPkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int arrayCount  = 4;                      // Arrays in the heap
  localparam int arrayLength = 4;                      // Elements per array
  localparam int elementBits = 12;                     // Element width

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  typedef logic [$clog2(arrayCount)-1:0]  arrayId_t;    // Array number
  typedef logic [$clog2(arrayLength)-1:0] elemIndex_t;  // Element index
  typedef logic [$clog2(arrayLength):0]   arraySize_t;  // Size, 0 to arrayLength
  typedef logic [elementBits-1:0]         element_t;    // Element value

  // Array counts that must reach arrayCount itself
  typedef logic [$clog2(arrayCount):0]    arrayTally_t;

endpackage

// File: common/heapOpPkg.sv
/*
  Heap operation and error codes, with the request and
  response structs carried on the client port
*/
package heapOpPkg;

  // --------------------------------------------------
  // Operation codes, 12 to 15 are illegal
  // --------------------------------------------------
  typedef enum logic [3:0] {
    opAlloc,                                           // Open a new array
    opFree,                                            // Release an array
    opWrite,                                           // Store at index
    opRead,                                            // Load from index
    opSize,                                            // Query size
    opPush,                                            // Append at end
    opPop,                                             // Remove from end
    opResize,                                          // Set size from data
    opAdd,                                             // Add, new value back
    opAddAfter,                                        // Add, old value back
    opSubtract,                                        // Subtract, new value back
    opXor                                              // Xor, new value back
  } heapOp_t;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                   // Also a double free
    errOutOfBounds,
    errFull,
    errEmpty,
    errNoMemory,
    errBadSize,
    errBadOp
  } heapError_t;

  // --------------------------------------------------
  // Port payloads
  // --------------------------------------------------
  typedef struct packed {
    heapOp_t                   op;                     // 4 bits
    heapConfigPkg::arrayId_t   array;                  // 2 bits
    heapConfigPkg::elemIndex_t index;                  // 2 bits
    heapConfigPkg::element_t   data;                   // 12 bits
  } heapRequest_t;

  typedef struct packed {
    heapConfigPkg::element_t data;                     // Zero on error
    heapError_t              error;
  } heapResponse_t;

endpackage

// File: design/heapAllocator.sv
/*
  Allocation flags, fresh-array counter and the
  last-in first-out stack of freed arrays
*/
module heapAllocator (
  input  logic                    clock,
  input  logic                    reset,               // Active low
  input  heapOpPkg::heapRequest_t heldRequest,
  input  logic                    commit,
  output logic                    isAllocated,         // Addressed array is open
  output logic                    canAllocate,
  output heapConfigPkg::arrayId_t newArray             // Number an alloc returns
);
  import heapConfigPkg::*;
  import heapOpPkg::*;

  logic [arrayCount-1:0] allocated;                    // One flag per array
  arrayId_t              freedStack [arrayCount];
  arrayTally_t           freedTop;                     // Entries on the stack
  arrayTally_t           freshCount;                   // Arrays ever taken
  logic                  haveFreed;

  // --------------------------------------------------
  // Status, freed arrays win over fresh ones
  // --------------------------------------------------
  assign haveFreed   = (freedTop != '0);
  assign isAllocated = allocated[heldRequest.array];
  assign canAllocate = haveFreed || (freshCount < arrayTally_t'(arrayCount));
  assign newArray    = haveFreed ? freedStack[arrayId_t'(freedTop - 1'b1)]
                                 : arrayId_t'(freshCount);

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated  <= '0;
      freedTop   <= '0;
      freshCount <= '0;
    end else if (commit) begin
      case (heldRequest.op)
        opAlloc: begin
          allocated[newArray] <= 1'b1;
          if (haveFreed) freedTop <= freedTop - 1'b1;  // Pop stack
          else freshCount <= freshCount + 1'b1;
        end
        opFree: begin
          allocated[heldRequest.array] <= 1'b0;        // Its own flag
          freedTop                     <= freedTop + 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // Stack body, never deeper than arrayCount
  always_ff @(posedge clock) begin
    if (commit && heldRequest.op == opFree) begin
      freedStack[arrayId_t'(freedTop)] <= heldRequest.array;
    end
  end

endmodule

// File: design/heapElementStore.sv
/*
  Element memory with slot selection and the
  add, subtract and xor unit
*/
module heapElementStore (
  input  logic                      clock,
  input  heapOpPkg::heapRequest_t   heldRequest,
  input  heapConfigPkg::arraySize_t size,              // Size of addressed array
  input  logic                      commit,
  output heapConfigPkg::element_t   element,           // Current slot value
  output heapConfigPkg::element_t   updated            // Value a commit stores
);
  import heapConfigPkg::*;
  import heapOpPkg::*;

  element_t   memory [arrayCount][arrayLength];        // Fixed blocks per array
  elemIndex_t slot;
  logic       storeSlot;

  // --------------------------------------------------
  // Slot and arithmetic
  // --------------------------------------------------
  always_comb begin
    case (heldRequest.op)
      opPush:  slot = elemIndex_t'(size);              // One past the end
      opPop:   slot = elemIndex_t'(size - 1'b1);       // Last element
      default: slot = heldRequest.index;
    endcase
  end

  assign element = memory[heldRequest.array][slot];

  always_comb begin
    case (heldRequest.op)
      opAdd, opAddAfter: updated = element + heldRequest.data;   // Wraps at 2^12
      opSubtract:        updated = element - heldRequest.data;
      opXor:             updated = element ^ heldRequest.data;
      default:           updated = heldRequest.data;             // Write and push
    endcase
  end

  assign storeSlot = commit && (heldRequest.op inside
                     {opWrite, opPush, opAdd, opAddAfter, opSubtract, opXor});

  always_ff @(posedge clock) begin
    if (storeSlot) memory[heldRequest.array][slot] <= updated;
  end

endmodule

// File: design/heapSequencer.sv
/*
  Request handshake and three-state controller, error
  priority, commit strobe and registered response
*/
module heapSequencer (
  input  logic                      clock,
  input  logic                      reset,             // Active low
  input  heapOpPkg::heapRequest_t   request,
  input  logic                      requestValid,
  output logic                      requestReady,
  output heapOpPkg::heapResponse_t  response,
  output logic                      responseValid,
  input  logic                      responseReady,
  output heapOpPkg::heapRequest_t   heldRequest,       // Fanned out to state blocks
  output logic                      commit,            // High for one cycle
  input  logic                      isAllocated,
  input  logic                      canAllocate,
  input  heapConfigPkg::arrayId_t   newArray,
  input  heapConfigPkg::arraySize_t size,
  input  logic                      inBounds,
  input  logic                      isFull,
  input  logic                      isEmpty,
  input  logic                      sizeFits,
  input  heapConfigPkg::element_t   element,
  input  heapConfigPkg::element_t   updated
);
  import heapConfigPkg::*;
  import heapOpPkg::*;

  typedef enum logic [1:0] {stIdle, stCheck, stRespond} seqState_t;

  seqState_t  state;
  heapError_t decidedError;                            // Winner of the priority
  element_t   resultData;
  logic       knownOp;

  assign requestReady = (state == stIdle) && !responseValid;

  // --------------------------------------------------
  // Error priority and response data
  // --------------------------------------------------
  always_comb begin
    knownOp      = 1'b1;
    decidedError = errNone;
    resultData   = '0;
    case (heldRequest.op)
      opAlloc: begin
        if (!canAllocate) decidedError = errNoMemory;
        resultData = element_t'(newArray);
      end
      opFree:  resultData = '0;
      opWrite: resultData = heldRequest.data;          // Echo
      opRead: begin
        if (!inBounds) decidedError = errOutOfBounds;
        resultData = element;
      end
      opSize:  resultData = element_t'(size);
      opPush: begin
        if (isFull) decidedError = errFull;
        resultData = heldRequest.data;
      end
      opPop: begin
        if (isEmpty) decidedError = errEmpty;
        resultData = element;                          // Slot at new size
      end
      opResize: begin
        if (!sizeFits) decidedError = errBadSize;
        resultData = heldRequest.data;
      end
      opAdd, opSubtract, opXor: begin
        if (!inBounds) decidedError = errOutOfBounds;
        resultData = updated;
      end
      opAddAfter: begin
        if (!inBounds) decidedError = errOutOfBounds;
        resultData = element;                          // Value before the add
      end
      default: knownOp = 1'b0;
    endcase
    // Overrides in priority order
    if (!knownOp) begin
      decidedError = errBadOp;
    end else if (heldRequest.op != opAlloc && !isAllocated) begin
      decidedError = errNotAllocated;
    end
    if (decidedError != errNone) resultData = '0;
  end

  // --------------------------------------------------
  // Controller
  // --------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state         <= stIdle;
      commit        <= 1'b0;
      responseValid <= 1'b0;
    end else begin
      commit <= 1'b0;                                  // Single-cycle pulse
      case (state)
        stIdle: begin
          if (requestValid && requestReady) state <= stCheck;
        end
        stCheck: begin
          commit <= (decidedError == errNone);         // Blocks update only when clean
          state  <= stRespond;
        end
        stRespond: begin
          if (!responseValid) begin
            responseValid <= 1'b1;                     // Same edge as the update
          end else if (responseReady) begin
            responseValid <= 1'b0;
            state         <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clock) begin
    if (requestValid && requestReady) heldRequest <= request;
    if (state == stCheck) begin
      response.data  <= resultData;
      response.error <= decidedError;
    end
  end

endmodule

// File: design/heapSizeTable.sv
/*
  Per-array sizes, bounds flags and the size rules
  of alloc, write, push, pop and resize
*/
module heapSizeTable (
  input  logic                      clock,
  input  logic                      reset,             // Active low
  input  heapOpPkg::heapRequest_t   heldRequest,
  input  logic                      commit,
  input  heapConfigPkg::arrayId_t   newArray,          // Target of an alloc
  output heapConfigPkg::arraySize_t size,
  output logic                      inBounds,          // index < size
  output logic                      isFull,
  output logic                      isEmpty,
  output logic                      sizeFits           // Resize value legal
);
  import heapConfigPkg::*;
  import heapOpPkg::*;

  arraySize_t sizes [arrayCount];
  arraySize_t grownSize;                               // Size after a write past end

  assign size      = sizes[heldRequest.array];
  assign inBounds  = arraySize_t'(heldRequest.index) < size;
  assign isFull    = (size == arraySize_t'(arrayLength));
  assign isEmpty   = (size == '0);
  assign sizeFits  = heldRequest.data <= element_t'(arrayLength);
  assign grownSize = arraySize_t'(heldRequest.index) + 1'b1;

  // --------------------------------------------------
  // Size updates
  // --------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < arrayCount; i++) sizes[i] <= '0;
    end else if (commit) begin
      case (heldRequest.op)
        opAlloc:  sizes[newArray] <= '0;               // Fresh array is empty
        opWrite:  if (!inBounds) sizes[heldRequest.array] <= grownSize;
        opPush:   sizes[heldRequest.array] <= size + 1'b1;
        opPop:    sizes[heldRequest.array] <= size - 1'b1;
        opResize: sizes[heldRequest.array] <= arraySize_t'(heldRequest.data);
        default: begin
        end
      endcase
    end
  end

endmodule

// File: design/heapTop.sv
/*
  Heap top level: sequencer plus allocator, size table
  and element store
*/
module heapTop (
  input  logic                     clock,
  input  logic                     reset,              // Active low
  input  heapOpPkg::heapRequest_t  request,
  input  logic                     requestValid,
  output logic                     requestReady,
  output heapOpPkg::heapResponse_t response,
  output logic                     responseValid,
  input  logic                     responseReady
);
  import heapConfigPkg::*;
  import heapOpPkg::*;

  heapRequest_t heldRequest;                           // Request under work
  logic         commit;                                // State update strobe
  logic         isAllocated;
  logic         canAllocate;
  arrayId_t     newArray;                              // Number an alloc returns
  arraySize_t   size;                                  // Size of addressed array
  logic         inBounds;
  logic         isFull;
  logic         isEmpty;
  logic         sizeFits;
  element_t     element;                               // Slot contents
  element_t     updated;                               // Value to store

  heapSequencer heapSequencer_inst (.*);

  heapAllocator heapAllocator_inst (.*);

  heapSizeTable heapSizeTable_inst (.*);

  heapElementStore heapElementStore_inst (.*);

endmodule

// File: files.f
common/heapConfigPkg.sv
common/heapOpPkg.sv
design/heapSequencer.sv
design/heapAllocator.sv
design/heapSizeTable.sv
design/heapElementStore.sv
design/heapTop.sv
verif/heapProtocol_assert.sv
verif/heapTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the heap testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f files.f --top-module heapTb -o heapSim
./obj_dir/heapSim | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  echo "Run passed"
else
  echo "Run failed"
  exit 1
fi

// File: verif/heapProtocol_assert.sv
/*
  Handshake assertions on the heap client port,
  bound into the top level
*/
module heapProtocol_assert (
  input logic                     clock,
  input logic                     reset,               // Active low
  input logic                     requestValid,
  input logic                     requestReady,
  input heapOpPkg::heapResponse_t response,
  input logic                     responseValid,
  input logic                     responseReady
);
  timeunit 1ns;
  timeprecision 100ps;

  // --------------------------------------------------
  // Response port
  // --------------------------------------------------
  assert property (@(posedge clock) disable iff (!reset)
    responseValid && !responseReady |=> responseValid && $stable(response))
    else $error("Response changed or dropped while stalled");

  assert property (@(posedge clock) disable iff (!reset)
    $rose(responseValid) |-> $past(requestValid && requestReady, 3))   // Raised at T+2
    else $error("Response did not follow an accepted request by two edges");

  assert property (@(posedge clock) !reset |-> !responseValid)
    else $error("Response valid during reset");

endmodule

bind heapTop heapProtocol_assert heapProtocol_assert_inst (.*);

// File: verif/heapTb.sv
/*
  Heap testbench: clock, reset, request sender, compare tasks,
  directed tests for every operation, watchdog and verdict
*/
module heapTb;
  timeunit 1ns;
  timeprecision 100ps;
  import heapConfigPkg::*;
  import heapOpPkg::*;

  localparam int clockPeriod  = 40;                    // ns
  localparam int resetCycles  = 10;
  localparam int requestCount = 53;                    // Requests over all tests
  localparam int timeoutNs    = requestCount * 6 * clockPeriod * 2;

  logic          clock;
  logic          reset;                                // Active low
  heapRequest_t  request;
  logic          requestValid;
  logic          requestReady;
  heapResponse_t response;
  logic          responseValid;
  logic          responseReady;

  int            dataErrors;
  int            codeErrors;
  integer        seed;

  heapTop heapTop_inst (.*);

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // Watchdog
  initial begin
    #(timeoutNs);
    $display("Timeout: the DUT stopped answering before all tests finished");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic checkData(input string testName, input element_t expected,
                           input element_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: data expected %03h, actual %03h", testName, expected, actual);
      dataErrors++;
    end
  endtask

  task automatic checkError(input string testName, input heapError_t expected,
                            input heapError_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: error expected %s, actual %s", testName, expected.name(),
               actual.name());
      codeErrors++;
    end
  endtask

  // --------------------------------------------------
  // Request sender
  // --------------------------------------------------
  task automatic sendRequest(input heapOp_t op, input arrayId_t array, input elemIndex_t index,
                             input element_t data, input int stallCycles,
                             output heapResponse_t result);
    heapRequest_t req;
    req.op    = op;
    req.array = array;
    req.index = index;
    req.data  = data;
    @(posedge clock);
    request       <= req;
    requestValid  <= 1'b1;
    responseReady <= (stallCycles == 0);               // Low to stall the response
    do @(negedge clock); while (!requestReady);
    @(posedge clock);                                  // Transfer edge
    requestValid <= 1'b0;
    do @(negedge clock); while (!responseValid);
    if (stallCycles > 0) begin
      repeat (stallCycles) @(negedge clock);
      @(posedge clock);
      responseReady <= 1'b1;
      @(negedge clock);
    end
    result = response;                                 // Stable at the falling edge
    @(posedge clock);                                  // Response taken here
  endtask

  task automatic runOp(input string testName, input heapOp_t op, input arrayId_t array,
                       input elemIndex_t index, input element_t data, input element_t expData,
                       input heapError_t expError, input int stallCycles = 0);
    heapResponse_t result;
    sendRequest(op, array, index, data, stallCycles, result);
    checkError(testName, expError, result.error);
    checkData(testName, expData, result.data);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic allocFreeReuse();
    for (int i = 0; i < arrayCount; i++) begin
      runOp("allocFree", opAlloc, '0, '0, '0, element_t'(i), errNone);
    end
    runOp("allocFree", opAlloc, '0, '0, '0, '0, errNoMemory);     // All four taken
    runOp("allocFree", opFree, 2'd2, '0, '0, '0, errNone);
    runOp("allocFree", opFree, 2'd1, '0, '0, '0, errNone);
    runOp("allocFree", opAlloc, '0, '0, '0, 12'd1, errNone);      // Last freed first
    runOp("allocFree", opAlloc, '0, '0, '0, 12'd2, errNone);
    runOp("allocFree", opFree, 2'd3, '0, '0, '0, errNone);
    runOp("allocFree", opFree, 2'd3, '0, '0, '0, errNotAllocated); // Double free
  endtask

  task automatic writeReadResize();
    element_t values [3];
    values = '{12'h123, 12'h456, 12'h789};
    for (int i = 0; i < 3; i++) begin
      runOp("writeRead", opWrite, 2'd0, elemIndex_t'(i), values[i], values[i], errNone);
    end
    runOp("writeRead", opSize, 2'd0, '0, '0, 12'd3, errNone);
    for (int i = 0; i < 3; i++) begin
      runOp("writeRead", opRead, 2'd0, elemIndex_t'(i), '0, values[i], errNone);
    end
    runOp("writeRead", opRead, 2'd0, 2'd3, '0, '0, errOutOfBounds);
    runOp("writeRead", opResize, 2'd0, '0, 12'd5, '0, errBadSize);
    runOp("writeRead", opResize, 2'd0, '0, 12'd1, 12'd1, errNone);
    runOp("writeRead", opSize, 2'd0, '0, '0, 12'd1, errNone);
  endtask

  task automatic pushPopOrder();
    element_t values [4];
    values = '{12'h111, 12'h222, 12'h333, 12'h444};
    for (int i = 0; i < arrayLength; i++) begin
      runOp("pushPop", opPush, 2'd1, '0, values[i], values[i], errNone);
    end
    runOp("pushPop", opPush, 2'd1, '0, 12'h555, '0, errFull);
    for (int i = arrayLength - 1; i >= 0; i--) begin
      runOp("pushPop", opPop, 2'd1, '0, '0, values[i], errNone);  // Reverse order
    end
    runOp("pushPop", opPop, 2'd1, '0, '0, '0, errEmpty);
  endtask

  task automatic elementArithmetic();
    element_t base [4];
    element_t operand [4];
    element_t expected [4];
    for (int i = 0; i < arrayLength; i++) begin
      base[i]    = element_t'($random(seed));
      operand[i] = element_t'($random(seed));
      runOp("arithmetic", opWrite, 2'd2, elemIndex_t'(i), base[i], base[i], errNone);
    end
    expected[0] = base[0] + operand[0];                // 12-bit wrap
    expected[1] = base[1] + operand[1];
    expected[2] = base[2] - operand[2];
    expected[3] = base[3] ^ operand[3];
    runOp("arithmetic", opAdd, 2'd2, 2'd0, operand[0], expected[0], errNone);
    runOp("arithmetic", opAddAfter, 2'd2, 2'd1, operand[1], base[1], errNone); // Old value
    runOp("arithmetic", opSubtract, 2'd2, 2'd2, operand[2], expected[2], errNone);
    runOp("arithmetic", opXor, 2'd2, 2'd3, operand[3], expected[3], errNone);
    for (int i = 0; i < arrayLength; i++) begin
      runOp("arithmetic", opRead, 2'd2, elemIndex_t'(i), '0, expected[i], errNone);
    end
  endtask

  task automatic accessBackPressure();
    runOp("accessStall", opRead, 2'd3, '0, '0, '0, errNotAllocated);   // Array 3 is freed
    runOp("accessStall", opWrite, 2'd3, '0, 12'h0AA, '0, errNotAllocated);
    runOp("accessStall", opSize, 2'd3, '0, '0, '0, errNotAllocated);
    runOp("accessStall", heapOp_t'(4'hC), 2'd0, '0, '0, '0, errBadOp);
    runOp("accessStall", heapOp_t'(4'hF), 2'd3, '0, '0, '0, errBadOp); // Beats not allocated
    // Response held back for six cycles
    runOp("accessStall", opPush, 2'd0, '0, 12'hABC, 12'hABC, errNone, 6);
    runOp("accessStall", opSize, 2'd0, '0, '0, 12'd2, errNone);        // Grew by one only
    runOp("accessStall", opRead, 2'd0, 2'd1, '0, 12'hABC, errNone);
    runOp("accessStall", opRead, 2'd0, 2'd0, '0, 12'h123, errNone);    // Untouched
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    reset         = 1'b0;
    request       = '0;
    requestValid  = 1'b0;
    responseReady = 1'b0;
    dataErrors    = 0;
    codeErrors    = 0;
    seed          = 27;
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b1;
    allocFreeReuse();
    writeReadResize();
    pushPopOrder();
    elementArithmetic();
    accessBackPressure();
    $display("Errors: %0d data, %0d error code", dataErrors, codeErrors);
    if (dataErrors + codeErrors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
